/* verilog/ProcessorPkg.sv */
`default_nettype none

package ProcessorPkg;

    localparam int DataWidth       = 32;                          // Data word width
    localparam int AddrWidth       = 32;                          // Instruction/data address
    localparam int GprAddrWidth    = 5;                           // 32 general registers
    localparam int MemWords        = 256;                         // Data memory depth
    localparam int ByteWidth       = 8;                           // One byte lane
    localparam int HalfWidth       = 16;                          // Two byte lanes
    localparam int BytesPerWord    = DataWidth / ByteWidth;       // Lanes per word
    localparam int ByteOffsetWidth = $clog2(BytesPerWord);        // Byte within word
    localparam int MemIndexWidth   = $clog2(MemWords);            // Word index bits
    localparam int InstBytes       = 4;                           // Fixed instruction size

    typedef logic [DataWidth-1:0]       Data;                     // Data word
    typedef logic [AddrWidth-1:0]       InstAddr;                 // Instruction address
    typedef logic [GprAddrWidth-1:0]    GprAddr;                  // Register index
    typedef logic [BytesPerWord-1:0]    ByteEnable;               // One bit per lane
    typedef logic [MemIndexWidth-1:0]   MemIndex;                 // Word index into memory
    typedef logic [ByteOffsetWidth-1:0] ByteOffset;               // Low address bits

    // Size of a load or store
    typedef enum logic [1:0] {
        DataAccessByte = 2'd0,                                    // 8 bit
        DataAccessHalf = 2'd1,                                    // 16 bit
        DataAccessWord = 2'd2                                     // 32 bit
    } DataAccess;

    // Source of the register writeback value
    typedef enum logic [1:0] {
        WrDataSelResult  = 2'd0,                                  // ALU result
        WrDataSelMemory  = 2'd1,                                  // Extended load data
        WrDataSelPcPlus4 = 2'd2                                   // Return address
    } WrDataSel;

endpackage

`default_nettype wire

/* verilog/PipelineExMem.sv */
`timescale 1ns/10ps
`default_nettype none

module PipelineExMem
(
    input  logic                   i_clock,
    input  logic                   i_arstN,        // Async, active low
    input  logic                   i_stall,        // Hold all, wins over flush
    input  logic                   i_flush,        // Insert a bubble

    input  logic                   i_isValid,
    input  ProcessorPkg::InstAddr  i_pc,
    input  ProcessorPkg::Data      i_dataR,        // ALU result, also data address
    input  ProcessorPkg::Data      i_dataB,        // Store data
    input  logic                   i_memWrEnable,
    input  logic                   i_memRdEnable,
    input  ProcessorPkg::DataAccess i_memAccess,
    input  logic                   i_memUnsigned,  // Zero extend loads
    input  ProcessorPkg::GprAddr   i_regWrAddr,
    input  logic                   i_regWrEnable,
    input  ProcessorPkg::WrDataSel i_regWrDataSel,

    output logic                   o_isValid,
    output ProcessorPkg::InstAddr  o_pc,
    output ProcessorPkg::Data      o_dataR,
    output ProcessorPkg::Data      o_dataB,
    output logic                   o_memWrEnable,
    output logic                   o_memRdEnable,
    output ProcessorPkg::DataAccess o_memAccess,
    output logic                   o_memUnsigned,
    output ProcessorPkg::GprAddr   o_regWrAddr,
    output logic                   o_regWrEnable,
    output ProcessorPkg::WrDataSel o_regWrDataSel
);

    // Control part, cleared by reset
    always_ff @(posedge i_clock or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            o_isValid     <= 1'b0;
            o_regWrEnable <= 1'b0;
        end
        else if (!i_stall)                                 // Stall keeps both
        begin
            o_isValid <= i_isValid & ~i_flush;             // Flush makes a bubble
            if (!i_flush)
                o_regWrEnable <= i_regWrEnable;
        end
    end

    // Payload part, loads only on a normal cycle
    always_ff @(posedge i_clock)
    begin
        if (!i_stall && !i_flush)
        begin
            o_pc           <= i_pc;
            o_dataR        <= i_dataR;
            o_dataB        <= i_dataB;
            o_memWrEnable  <= i_memWrEnable;               // Gated by valid downstream
            o_memRdEnable  <= i_memRdEnable;
            o_memAccess    <= i_memAccess;
            o_memUnsigned  <= i_memUnsigned;
            o_regWrAddr    <= i_regWrAddr;
            o_regWrDataSel <= i_regWrDataSel;
        end
    end

endmodule

`default_nettype wire

/* verilog/MemoryAccess.sv */
`timescale 1ns/10ps
`default_nettype none

module MemoryAccess
(
    input  logic                    i_isValid,       // EX/MEM slot holds an instruction
    input  logic                    i_stall,
    input  logic                    i_memWrEnable,
    input  logic                    i_memRdEnable,
    input  logic                    i_memUnsigned,   // Zero instead of sign extension
    input  ProcessorPkg::InstAddr   i_pc,
    input  ProcessorPkg::Data       i_dataR,         // ALU result
    input  ProcessorPkg::Data       i_dataB,         // Store data
    input  ProcessorPkg::Data       i_rdData,        // Word read from memory
    input  ProcessorPkg::ByteOffset i_byteOffset,    // Address bits 1..0
    input  ProcessorPkg::DataAccess i_memAccess,
    input  ProcessorPkg::WrDataSel  i_regWrDataSel,

    output logic                    o_wrEnable,
    output ProcessorPkg::ByteEnable o_byteEnable,
    output ProcessorPkg::Data       o_wrData,
    output ProcessorPkg::Data       o_wbData
);

    logic [ProcessorPkg::ByteWidth-1:0] loadByte;     // Addressed byte, at bit 0
    logic [ProcessorPkg::HalfWidth-1:0] loadHalf;     // Addressed halfword, at bit 0
    logic                               byteFill;     // Extension bit for bytes
    logic                               halfFill;     // Extension bit for halves
    ProcessorPkg::Data                  loadData;     // Extended load value

    // A stalled store waits and writes once when the stall drops
    assign o_wrEnable = i_isValid & i_memWrEnable & ~i_stall;

    // Lane enables and replicated store data
    always_comb
    begin
        case (i_memAccess)
            ProcessorPkg::DataAccessByte:
            begin
                o_byteEnable = ProcessorPkg::ByteEnable'(1) << i_byteOffset;
                o_wrData     = {ProcessorPkg::BytesPerWord{i_dataB[ProcessorPkg::ByteWidth-1:0]}};
            end
            ProcessorPkg::DataAccessHalf:
            begin
                // Bit 0 ignored, lower or upper pair
                o_byteEnable = ProcessorPkg::ByteEnable'(2'b11) << {i_byteOffset[1], 1'b0};
                o_wrData     = {(ProcessorPkg::BytesPerWord / 2){
                                   i_dataB[ProcessorPkg::HalfWidth-1:0]}};
            end
            ProcessorPkg::DataAccessWord:
            begin
                o_byteEnable = '1;                              // Offset ignored
                o_wrData     = i_dataB;
            end
            default:
            begin
                o_byteEnable = '0;                              // Unused encoding
                o_wrData     = i_dataB;
            end
        endcase
    end

    // Shift the addressed lanes down to bit 0
    assign loadByte = i_rdData[i_byteOffset * ProcessorPkg::ByteWidth +: ProcessorPkg::ByteWidth];
    assign loadHalf = i_rdData[i_byteOffset[1] * ProcessorPkg::HalfWidth +: ProcessorPkg::HalfWidth];
    assign byteFill = ~i_memUnsigned & loadByte[ProcessorPkg::ByteWidth-1];
    assign halfFill = ~i_memUnsigned & loadHalf[ProcessorPkg::HalfWidth-1];

    always_comb
    begin
        case (i_memAccess)
            ProcessorPkg::DataAccessByte:
                loadData = {{(ProcessorPkg::DataWidth - ProcessorPkg::ByteWidth){byteFill}}, loadByte};
            ProcessorPkg::DataAccessHalf:
                loadData = {{(ProcessorPkg::DataWidth - ProcessorPkg::HalfWidth){halfFill}}, loadHalf};
            default:
                loadData = i_rdData;                            // Whole word
        endcase
    end

    // Writeback source
    always_comb
    begin
        case (i_regWrDataSel)
            ProcessorPkg::WrDataSelResult:  o_wbData = i_dataR;
            ProcessorPkg::WrDataSelMemory:  o_wbData = i_memRdEnable ? loadData : '0;  // No read, zero
            ProcessorPkg::WrDataSelPcPlus4:
                o_wbData = i_pc + ProcessorPkg::InstAddr'(ProcessorPkg::InstBytes);   // Link value
            default:                        o_wbData = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/DataMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module DataMemory
(
    input  logic                    i_clock,
    input  logic                    i_wrEnable,     // Already qualified by valid and stall
    input  ProcessorPkg::ByteEnable i_byteEnable,   // Lanes to write
    input  ProcessorPkg::MemIndex   i_index,        // Word index
    input  ProcessorPkg::Data       i_wrData,       // Lane replicated store data
    output ProcessorPkg::Data       o_rdData        // Zero latency read
);

    ProcessorPkg::Data mem [ProcessorPkg::MemWords];   // Undefined until written

    // Per lane write on the edge
    always_ff @(posedge i_clock)
    begin
        if (i_wrEnable)
        begin
            for (int lane = 0; lane < ProcessorPkg::BytesPerWord; lane++)
            begin
                if (i_byteEnable[lane])
                    mem[i_index][lane * ProcessorPkg::ByteWidth +: ProcessorPkg::ByteWidth] <=
                        i_wrData[lane * ProcessorPkg::ByteWidth +: ProcessorPkg::ByteWidth];
            end
        end
    end

    // Read through, a store is visible on the next cycle
    assign o_rdData = mem[i_index];

endmodule

`default_nettype wire

/* verilog/PipelineMemWb.sv */
`timescale 1ns/10ps
`default_nettype none

module PipelineMemWb
(
    input  logic                  i_clock,
    input  logic                  i_arstN,        // Async, active low
    input  logic                  i_stall,        // Hold everything
    input  logic                  i_isValid,
    input  logic                  i_regWrEnable,
    input  ProcessorPkg::InstAddr i_pc,
    input  ProcessorPkg::GprAddr  i_regWrAddr,
    input  ProcessorPkg::Data     i_wbData,       // Selected writeback value

    output logic                  o_isValid,
    output ProcessorPkg::InstAddr o_pc,
    output ProcessorPkg::GprAddr  o_regWrAddr,
    output logic                  o_regWrEnable,
    output ProcessorPkg::Data     o_wbData
);

    // Control, no flush here since MEM is past the commit point
    always_ff @(posedge i_clock or negedge i_arstN)
    begin
        if (!i_arstN)
        begin
            o_isValid     <= 1'b0;
            o_regWrEnable <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_isValid     <= i_isValid;
            o_regWrEnable <= i_regWrEnable;
        end
    end

    // Payload
    always_ff @(posedge i_clock)
    begin
        if (!i_stall)
        begin
            o_pc        <= i_pc;
            o_regWrAddr <= i_regWrAddr;
            o_wbData    <= i_wbData;
        end
    end

endmodule

`default_nettype wire

/* verilog/MemoryStage.sv */
`timescale 1ns/10ps
`default_nettype none

module MemoryStage
(
    input  logic                    i_clock,
    input  logic                    i_arstN,
    input  logic                    i_stall,        // Holds both registers
    input  logic                    i_flush,        // Bubbles the EX/MEM slot

    input  logic                    i_isValid,
    input  ProcessorPkg::InstAddr   i_pc,
    input  ProcessorPkg::Data       i_dataR,
    input  ProcessorPkg::Data       i_dataB,
    input  logic                    i_memWrEnable,
    input  logic                    i_memRdEnable,
    input  ProcessorPkg::DataAccess i_memAccess,
    input  logic                    i_memUnsigned,
    input  ProcessorPkg::GprAddr    i_regWrAddr,
    input  logic                    i_regWrEnable,
    input  ProcessorPkg::WrDataSel  i_regWrDataSel,

    output logic                    o_wbValid,
    output ProcessorPkg::InstAddr   o_wbPc,
    output ProcessorPkg::GprAddr    o_wbRegWrAddr,
    output logic                    o_wbRegWrEnable,
    output ProcessorPkg::Data       o_wbData
);

    logic                    memIsValid;         // EX/MEM outputs
    ProcessorPkg::InstAddr   memPc;
    ProcessorPkg::Data       memDataR;           // Also the data address
    ProcessorPkg::Data       memDataB;
    logic                    memWrEnable;
    logic                    memRdEnable;
    ProcessorPkg::DataAccess memAccess;
    logic                    memUnsigned;
    ProcessorPkg::GprAddr    memRegWrAddr;
    logic                    memRegWrEnable;
    ProcessorPkg::WrDataSel  memRegWrDataSel;

    ProcessorPkg::MemIndex   memIndex;           // Address bits 9..2
    ProcessorPkg::ByteOffset byteOffset;         // Address bits 1..0
    logic                    ramWrEnable;
    ProcessorPkg::ByteEnable ramByteEnable;
    ProcessorPkg::Data       ramWrData;
    ProcessorPkg::Data       ramRdData;
    ProcessorPkg::Data       wbData;             // Into MEM/WB

    assign memIndex   = memDataR[ProcessorPkg::MemIndexWidth + ProcessorPkg::ByteOffsetWidth - 1 :
                                 ProcessorPkg::ByteOffsetWidth];
    assign byteOffset = memDataR[ProcessorPkg::ByteOffsetWidth-1:0];

    PipelineExMem exMem (
        .i_clock(i_clock), .i_arstN(i_arstN), .i_stall(i_stall), .i_flush(i_flush),
        .i_isValid(i_isValid), .i_pc(i_pc), .i_dataR(i_dataR), .i_dataB(i_dataB),
        .i_memWrEnable(i_memWrEnable), .i_memRdEnable(i_memRdEnable),
        .i_memAccess(i_memAccess), .i_memUnsigned(i_memUnsigned),
        .i_regWrAddr(i_regWrAddr), .i_regWrEnable(i_regWrEnable),
        .i_regWrDataSel(i_regWrDataSel),
        .o_isValid(memIsValid), .o_pc(memPc), .o_dataR(memDataR), .o_dataB(memDataB),
        .o_memWrEnable(memWrEnable), .o_memRdEnable(memRdEnable),
        .o_memAccess(memAccess), .o_memUnsigned(memUnsigned),
        .o_regWrAddr(memRegWrAddr), .o_regWrEnable(memRegWrEnable),
        .o_regWrDataSel(memRegWrDataSel));

    MemoryAccess access (
        .i_isValid(memIsValid), .i_stall(i_stall), .i_memWrEnable(memWrEnable),
        .i_memRdEnable(memRdEnable), .i_memUnsigned(memUnsigned), .i_pc(memPc),
        .i_dataR(memDataR), .i_dataB(memDataB), .i_rdData(ramRdData),
        .i_byteOffset(byteOffset), .i_memAccess(memAccess),
        .i_regWrDataSel(memRegWrDataSel),
        .o_wrEnable(ramWrEnable), .o_byteEnable(ramByteEnable),
        .o_wrData(ramWrData), .o_wbData(wbData));

    DataMemory dataMem (
        .i_clock(i_clock), .i_wrEnable(ramWrEnable), .i_byteEnable(ramByteEnable),
        .i_index(memIndex), .i_wrData(ramWrData), .o_rdData(ramRdData));

    PipelineMemWb memWb (
        .i_clock(i_clock), .i_arstN(i_arstN), .i_stall(i_stall),
        .i_isValid(memIsValid), .i_regWrEnable(memRegWrEnable), .i_pc(memPc),
        .i_regWrAddr(memRegWrAddr), .i_wbData(wbData),
        .o_isValid(o_wbValid), .o_pc(o_wbPc), .o_regWrAddr(o_wbRegWrAddr),
        .o_regWrEnable(o_wbRegWrEnable), .o_wbData(o_wbData));

endmodule

`default_nettype wire

/* tb/ClockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module ClockGen
(
    output logic o_clock,
    output logic o_arstN
);

    localparam time HalfPeriod  = 20ns;                 // 40 ns clock
    localparam int  ResetCycles = 8;

    initial
    begin
        o_clock = 1'b0;
        forever #HalfPeriod o_clock = ~o_clock;
    end

    initial
    begin
        o_arstN = 1'b0;                                 // Held from time zero
        repeat (ResetCycles) @(posedge o_clock);
        #5 o_arstN = 1'b1;                              // Release clear of the edge
    end

endmodule

`default_nettype wire

/* tb/MemoryStageTb.sv */
`timescale 1ns/10ps
`default_nettype none

module MemoryStageTb;

    localparam time WatchdogTime = 400 * 40ns;          // Test length with margin

    logic clock, arstN, stall, flush, isValid, memWrEnable, memRdEnable, memUnsigned, regWrEnable;
    ProcessorPkg::InstAddr   pc, wbPc, pcCount;
    ProcessorPkg::Data       dataR, dataB, wbData;
    ProcessorPkg::DataAccess memAccess;
    ProcessorPkg::GprAddr    regWrAddr, wbRegWrAddr;
    ProcessorPkg::WrDataSel  regWrDataSel;
    logic                    wbValid, wbRegWrEnable;
    logic [31:0]             rngState, lastWordAddr;
    logic [7:0]              refMem [1024];             // Byte image of the data memory
    int                      errors;

    ClockGen clockGen (.o_clock(clock), .o_arstN(arstN));

    MemoryStage uut (
        .i_clock(clock), .i_arstN(arstN), .i_stall(stall), .i_flush(flush),
        .i_isValid(isValid), .i_pc(pc), .i_dataR(dataR), .i_dataB(dataB),
        .i_memWrEnable(memWrEnable), .i_memRdEnable(memRdEnable), .i_memAccess(memAccess),
        .i_memUnsigned(memUnsigned), .i_regWrAddr(regWrAddr), .i_regWrEnable(regWrEnable),
        .i_regWrDataSel(regWrDataSel),
        .o_wbValid(wbValid), .o_wbPc(wbPc), .o_wbRegWrAddr(wbRegWrAddr),
        .o_wbRegWrEnable(wbRegWrEnable), .o_wbData(wbData));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] randomWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Expected load value from the byte image
    function automatic logic [31:0] expectLoad(input logic [31:0] a,
                                               input ProcessorPkg::DataAccess acc, input logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = refMem[a[9:0]];
        h = {refMem[{a[9:1], 1'b1}], refMem[{a[9:1], 1'b0}]};      // Bit 0 ignored
        if (acc == ProcessorPkg::DataAccessByte)
            return uns ? {24'd0, b} : {{24{b[7]}}, b};
        if (acc == ProcessorPkg::DataAccessHalf)
            return uns ? {16'd0, h} : {{16{h[15]}}, h};
        return {refMem[{a[9:2], 2'd3}], refMem[{a[9:2], 2'd2}],
                refMem[{a[9:2], 2'd1}], refMem[{a[9:2], 2'd0}]};
    endfunction

    task automatic updateRef(input logic [31:0] a, input ProcessorPkg::DataAccess acc,
                             input logic [31:0] d);
        if (acc == ProcessorPkg::DataAccessByte)
            refMem[a[9:0]] = d[7:0];
        else if (acc == ProcessorPkg::DataAccessHalf)
        begin
            refMem[{a[9:1], 1'b0}] = d[7:0];
            refMem[{a[9:1], 1'b1}] = d[15:8];
        end
        else
            for (int lane = 0; lane < 4; lane++)
                refMem[{a[9:2], lane[1:0]}] = d[lane*8 +: 8];
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic step();
        @(posedge clock);
        #5;                                             // Drive and sample point
    endtask

    task automatic idle();
        isValid      = 1'b0;
        pc           = '0;
        dataR        = '0;
        dataB        = '0;
        memWrEnable  = 1'b0;
        memRdEnable  = 1'b0;
        memAccess    = ProcessorPkg::DataAccessWord;
        memUnsigned  = 1'b0;
        regWrAddr    = '0;
        regWrEnable  = 1'b0;
        regWrDataSel = ProcessorPkg::WrDataSelResult;
    endtask

    task automatic driveInst(input ProcessorPkg::InstAddr p, input logic [31:0] r, b,
                             input logic wr, rd, input ProcessorPkg::DataAccess acc,
                             input logic uns, input ProcessorPkg::GprAddr ra, input logic we,
                             input ProcessorPkg::WrDataSel sel);
        isValid      = 1'b1;
        pc           = p;
        dataR        = r;                               // Also the data address
        dataB        = b;
        memWrEnable  = wr;
        memRdEnable  = rd;
        memAccess    = acc;
        memUnsigned  = uns;
        regWrAddr    = ra;
        regWrEnable  = we;
        regWrDataSel = sel;
    endtask

    task automatic checkWb(input logic v, input ProcessorPkg::InstAddr p,
                           input ProcessorPkg::GprAddr ra, input logic we, input logic [31:0] d);
        checkValue("o_wbValid", {31'd0, v}, {31'd0, wbValid});
        checkValue("o_wbPc", p, wbPc);
        checkValue("o_wbRegWrAddr", {27'd0, ra}, {27'd0, wbRegWrAddr});
        checkValue("o_wbRegWrEnable", {31'd0, we}, {31'd0, wbRegWrEnable});
        checkValue("o_wbData", d, wbData);
    endtask

    // One instruction alone, result two edges later
    task automatic storeMem(input logic [31:0] a, input ProcessorPkg::DataAccess acc,
                            input logic [31:0] d);
        ProcessorPkg::InstAddr p;
        p = pcCount;
        pcCount += 4;
        driveInst(p, a, d, 1'b1, 1'b0, acc, 1'b0, '0, 1'b0, ProcessorPkg::WrDataSelResult);
        step();
        idle();
        step();
        checkWb(1'b1, p, '0, 1'b0, a);
        updateRef(a, acc, d);
    endtask

    task automatic loadCheck(input logic [31:0] a, input ProcessorPkg::DataAccess acc,
                             input logic uns);
        ProcessorPkg::InstAddr p;
        ProcessorPkg::GprAddr  ra;
        p = pcCount;
        pcCount += 4;
        ra = ProcessorPkg::GprAddr'(randomWord());
        driveInst(p, a, '0, 1'b0, 1'b1, acc, uns, ra, 1'b1, ProcessorPkg::WrDataSelMemory);
        step();
        idle();
        step();
        checkWb(1'b1, p, ra, 1'b1, expectLoad(a, acc, uns));
    endtask

    task automatic testReset();
        repeat (3) @(posedge clock);
        #5;
        checkValue("o_wbValid", 32'd0, {31'd0, wbValid});              // Inside reset
        checkValue("o_wbRegWrEnable", 32'd0, {31'd0, wbRegWrEnable});
        wait (arstN);
        step();
        step();
        checkValue("o_wbValid", 32'd0, {31'd0, wbValid});              // Bubbles only
        checkValue("o_wbRegWrEnable", 32'd0, {31'd0, wbRegWrEnable});
    endtask

    task automatic testWordStoreLoad();
        logic [31:0] addrs [6];
        for (int i = 0; i < 6; i++)
        begin
            addrs[i] = randomWord() & 32'h3fc;
            storeMem(addrs[i], ProcessorPkg::DataAccessWord, randomWord());
        end
        for (int i = 0; i < 6; i++)
            loadCheck(addrs[i], ProcessorPkg::DataAccessWord, 1'b0);
        lastWordAddr = addrs[0];
    endtask

    task automatic testSubWord();
        logic [31:0] base;
        for (int w = 0; w < 2; w++)
        begin
            base = randomWord() & 32'h3fc;
            storeMem(base, ProcessorPkg::DataAccessWord, w == 0 ? 32'h807f_ff01 : randomWord());
            for (int off = 0; off < 4; off++)
                for (int u = 0; u < 2; u++)
                begin
                    loadCheck(base + off, ProcessorPkg::DataAccessByte, u[0]);
                    loadCheck(base + off, ProcessorPkg::DataAccessHalf, u[0]);
                end
            for (int off = 0; off < 4; off++)
            begin
                storeMem(base + off, ProcessorPkg::DataAccessByte, randomWord());
                loadCheck(base, ProcessorPkg::DataAccessWord, 1'b0);   // Other lanes intact
            end
            storeMem(base + 1, ProcessorPkg::DataAccessHalf, randomWord());  // Lower pair
            storeMem(base + 2, ProcessorPkg::DataAccessHalf, randomWord());  // Upper pair
            loadCheck(base, ProcessorPkg::DataAccessWord, 1'b0);
        end
    endtask

    task automatic testWbSelect();
        ProcessorPkg::InstAddr p;
        ProcessorPkg::Data     r;
        p = randomWord();
        r = randomWord();
        driveInst(p, r, '0, 1'b0, 1'b0, ProcessorPkg::DataAccessWord, 1'b0, 5'd7, 1'b1,
                  ProcessorPkg::WrDataSelResult);
        step();
        idle();
        step();
        checkWb(1'b1, p, 5'd7, 1'b1, r);
        p = randomWord();
        driveInst(p, r, '0, 1'b0, 1'b0, ProcessorPkg::DataAccessWord, 1'b0, 5'd31, 1'b0,
                  ProcessorPkg::WrDataSelPcPlus4);
        step();
        idle();
        step();
        checkWb(1'b1, p, 5'd31, 1'b0, p + 32'd4);       // Link address
        p = randomWord();
        driveInst(p, lastWordAddr, '0, 1'b0, 1'b0, ProcessorPkg::DataAccessWord, 1'b0, 5'd4,
                  1'b1, ProcessorPkg::WrDataSelMemory);
        step();
        idle();
        step();
        checkWb(1'b1, p, 5'd4, 1'b1, 32'd0);            // Memory selected, read off
    endtask

    task automatic testFlush();
        flush = 1'b1;
        driveInst(pcCount, lastWordAddr, ~expectLoad(lastWordAddr, ProcessorPkg::DataAccessWord,
                  1'b0), 1'b1, 1'b0, ProcessorPkg::DataAccessWord, 1'b0, 5'd3, 1'b1,
                  ProcessorPkg::WrDataSelResult);
        step();
        flush = 1'b0;
        idle();
        step();
        checkValue("o_wbValid", 32'd0, {31'd0, wbValid});              // Slot is a bubble
        loadCheck(lastWordAddr, ProcessorPkg::DataAccessWord, 1'b0);   // Old word still there
    endtask

    task automatic testStall();
        ProcessorPkg::InstAddr p0, p1, p2;
        logic [31:0]           d, a, oldWord;
        p0 = pcCount;
        p1 = pcCount + 4;
        p2 = pcCount + 8;
        pcCount += 12;
        a = randomWord() & 32'h3fc;
        storeMem(a, ProcessorPkg::DataAccessWord, randomWord());
        oldWord = expectLoad(a, ProcessorPkg::DataAccessWord, 1'b0);
        d = ~oldWord;
        driveInst(p0, 32'h1234_5678, '0, 1'b0, 1'b0, ProcessorPkg::DataAccessWord, 1'b0, 5'd9,
                  1'b1, ProcessorPkg::WrDataSelResult);
        step();
        driveInst(p1, a, d, 1'b1, 1'b0, ProcessorPkg::DataAccessWord, 1'b0, '0, 1'b0,
                  ProcessorPkg::WrDataSelResult);
        step();
        stall = 1'b1;                                   // Store now sits in MEM
        driveInst(p2, a, '0, 1'b0, 1'b1, ProcessorPkg::DataAccessWord, 1'b0, 5'd12, 1'b1,
                  ProcessorPkg::WrDataSelMemory);
        for (int i = 0; i < 3; i++)
        begin
            step();
            checkWb(1'b1, p0, 5'd9, 1'b1, 32'h1234_5678);             // WB keeps p0
            checkValue("dataMem.mem", oldWord, uut.dataMem.mem[a[9:2]]);  // No early write
        end
        stall = 1'b0;
        step();
        idle();
        updateRef(a, ProcessorPkg::DataAccessWord, d);
        checkWb(1'b1, p1, '0, 1'b0, a);                 // Store reaches WB first
        step();
        checkWb(1'b1, p2, 5'd12, 1'b1, d);              // Then the load, seeing the store
    endtask

    initial
    begin
        #WatchdogTime;
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        errors   = 0;
        rngState = 32'h37ba_da10;
        pcCount  = 32'h0000_1000;
        stall    = 1'b0;
        flush    = 1'b0;
        idle();
        testReset();
        testWordStoreLoad();
        testSubWord();
        testWbSelect();
        testFlush();
        testStall();
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* MemoryStage.f */
verilog/ProcessorPkg.sv
verilog/PipelineExMem.sv
verilog/MemoryAccess.sv
verilog/DataMemory.sv
verilog/PipelineMemWb.sv
verilog/MemoryStage.sv
tb/ClockGen.sv
tb/MemoryStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the MemoryStage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f MemoryStage.f --top-module MemoryStageTb -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi

exit 0
